// ==== Bender.yml ====
package:
  name: mc_mem_harness

sources:
  # packages first, then the design from the leaves up
  - logic/mc_machine_pkg.sv
  - logic/mc_dma_pkg.sv
  - logic/mc_boot_ctrl.sv
  - logic/mc_dma_channel_map.sv
  - logic/mc_test_dram.sv
  - logic/mc_mem_harness.sv

  # testbench and bound checker
  - target: simulation
    files:
      - verification/mc_mem_harness_chk.sv
      - verification/tb_mc_mem_harness.sv

// ==== flist.f ====
logic/mc_machine_pkg.sv
logic/mc_dma_pkg.sv
logic/mc_boot_ctrl.sv
logic/mc_dma_channel_map.sv
logic/mc_test_dram.sv
logic/mc_mem_harness.sv
verification/mc_mem_harness_chk.sv
verification/tb_mc_mem_harness.sv

// ==== logic/mc_boot_ctrl.sv ====
module mc_boot_ctrl #(
  parameter int reset_depth_p = 3
) (
  input  logic clk_i
  , input  logic arst_n_i

  , output logic tag_done_o
  , output logic core_reset_o
);

  mc_machine_pkg::boot_state_e state_r;

  logic [mc_machine_pkg::TAG_CNT_W-1:0] tag_cnt_r;
  logic                                 tag_last;

  // delay chain, oldest stage at the top
  logic [reset_depth_p-1:0] chain_r;

  assign tag_last = (tag_cnt_r == (mc_machine_pkg::TAG_CYCLES - 1));

  ////////////////////
  // tag sequencer
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r   <= mc_machine_pkg::BOOT_TAG;
      tag_cnt_r <= '0;
    end else begin
      case (state_r)
        mc_machine_pkg::BOOT_TAG: begin
          tag_cnt_r <= tag_cnt_r + 1'b1;
          if (tag_last) begin
            state_r <= mc_machine_pkg::BOOT_HOLD;
          end
        end
        mc_machine_pkg::BOOT_HOLD: begin
          // chain has drained
          if (!chain_r[reset_depth_p-1]) begin
            state_r <= mc_machine_pkg::BOOT_RUN;
          end
        end
        default: begin
          state_r <= state_r;
        end
      endcase
    end
  end

  // high from the last tag bit onward
  assign tag_done_o = (state_r != mc_machine_pkg::BOOT_TAG);

  ////////////////////
  // core reset delay
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      chain_r <= '1;
    end else begin
      chain_r[0] <= ~tag_done_o;
      for (int i = 1; i < reset_depth_p; i++) begin
        chain_r[i] <= chain_r[i-1];
      end
    end
  end

  assign core_reset_o = chain_r[reset_depth_p-1];

endmodule

// ==== logic/mc_dma_channel_map.sv ====
module mc_dma_channel_map #(
  parameter int num_vcaches_p = 4
) (
  input  logic clk_i
  , input  logic arst_n_i
  , input  logic core_reset_i

  // requester side
  , input  mc_dma_pkg::dma_req_s [num_vcaches_p-1:0] req_i
  , output logic [num_vcaches_p-1:0]                 yumi_o

  // channel side
  , output mc_dma_pkg::chan_req_s chan_req_o
  , input  mc_dma_pkg::chan_rsp_s chan_rsp_i

  // responses back to requesters
  , output mc_dma_pkg::dma_rsp_s [num_vcaches_p-1:0] rsp_o
);

  // index of the most recent winner
  mc_dma_pkg::id_t last_r;

  logic            found;
  mc_dma_pkg::id_t pick_id;
  logic            grant;

  ////////////////////
  // round robin pick
  ////////////////////

  // scan starts one past the last winner and wraps
  always_comb begin
    int idx;
    found   = 1'b0;
    pick_id = '0;
    idx     = 0;
    for (int k = 1; k <= num_vcaches_p; k++) begin
      idx = (int'(last_r) + k) % num_vcaches_p;
      if (!found && req_i[idx].v) begin
        found   = 1'b1;
        pick_id = mc_dma_pkg::id_t'(idx);
      end
    end
  end

  // nothing goes out while the cores sit in reset
  assign grant = found & ~core_reset_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // first search then begins at requester 0
      last_r <= mc_dma_pkg::id_t'(num_vcaches_p - 1);
    end else if (grant) begin
      last_r <= pick_id;
    end
  end

  assign yumi_o = grant ? (num_vcaches_p'(1) << pick_id) : '0;

  ////////////////////
  // forward to channel
  ////////////////////

  always_comb begin
    chan_req_o.v    = grant;
    chan_req_o.op   = req_i[pick_id].op;
    chan_req_o.addr = req_i[pick_id].addr;
    chan_req_o.data = req_i[pick_id].data;
    chan_req_o.id   = pick_id;
  end

  ////////////////////
  // response demux
  ////////////////////

  // data fans out to all, valid only to the named requester
  always_comb begin
    for (int i = 0; i < num_vcaches_p; i++) begin
      rsp_o[i].v    = chan_rsp_i.v && (chan_rsp_i.id == mc_dma_pkg::id_t'(i));
      rsp_o[i].data = chan_rsp_i.data;
    end
  end

endmodule

// ==== logic/mc_dma_pkg.sv ====
package mc_dma_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int DATA_W = 32;
  localparam int ADDR_W = 10;

  // fixed id field, room for 16 requesters
  localparam int ID_W = 4;

  typedef logic [ID_W-1:0] id_t;

  typedef enum logic {
    DMA_READ  = 1'b0,
    DMA_WRITE = 1'b1
  } dma_op_e;

  ////////////////////
  // address layouts
  ////////////////////

  // word address as the vcache dma emits it
  typedef struct packed {
    logic [1:0] ba;
    logic       bg;
    logic [2:0] ro;
    logic [3:0] co;
  } cache_addr_s;

  // row first order used inside the dram
  typedef struct packed {
    logic [2:0] ro;
    logic       bg;
    logic [1:0] ba;
    logic [3:0] co;
  } dram_addr_s;

  ////////////////////
  // requests and responses
  ////////////////////

  typedef struct packed {
    logic              v;
    dma_op_e           op;
    cache_addr_s       addr;
    logic [DATA_W-1:0] data;
  } dma_req_s;

  typedef struct packed {
    logic              v;
    logic [DATA_W-1:0] data;
  } dma_rsp_s;

  // granted request, tagged with the requester
  typedef struct packed {
    logic              v;
    dma_op_e           op;
    cache_addr_s       addr;
    logic [DATA_W-1:0] data;
    id_t               id;
  } chan_req_s;

  typedef struct packed {
    logic              v;
    logic [DATA_W-1:0] data;
    id_t               id;
  } chan_rsp_s;

endpackage

// ==== logic/mc_machine_pkg.sv ====
package mc_machine_pkg;

  ////////////////////
  // pod geometry
  ////////////////////

  // pods that receive a tag during boot
  localparam int NUM_PODS = 2;

  // serial tag bits shifted into each pod
  localparam int TAG_BITS_PER_POD = 8;

  // one tag bit per cycle, so this is the
  // full length of the programming phase
  localparam int TAG_CYCLES = NUM_PODS * TAG_BITS_PER_POD;

  // counter width for the programming phase
  localparam int TAG_CNT_W = $clog2(TAG_CYCLES);

  ////////////////////
  // boot sequence
  ////////////////////

  // tag  -> pod tags being shifted out
  // hold -> tags done, core reset still held
  // run  -> core reset released
  typedef enum logic [1:0] {
    BOOT_TAG  = 2'd0,
    BOOT_HOLD = 2'd1,
    BOOT_RUN  = 2'd2
  } boot_state_e;

endpackage

// ==== logic/mc_mem_harness.sv ====
module mc_mem_harness #(
  parameter int num_vcaches_p  = 4
  , parameter int reset_depth_p  = 3
  , parameter int dram_latency_p = 4
) (
  input  logic clk_i
  , input  logic arst_n_i

  , output logic tag_done_o

  , input  mc_dma_pkg::dma_req_s [num_vcaches_p-1:0] dma_req_i
  , output logic [num_vcaches_p-1:0]                 dma_req_yumi_o
  , output mc_dma_pkg::dma_rsp_s [num_vcaches_p-1:0] dma_rsp_o
);

  logic                  core_reset;
  mc_dma_pkg::chan_req_s chan_req;
  mc_dma_pkg::chan_rsp_s chan_rsp;

  // tag master and core reset chain
  mc_boot_ctrl #(
    .reset_depth_p(reset_depth_p)
  ) boot (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.tag_done_o(tag_done_o)
    ,.core_reset_o(core_reset)
  );

  // vcaches onto the single channel
  mc_dma_channel_map #(
    .num_vcaches_p(num_vcaches_p)
  ) chan_map (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.core_reset_i(core_reset)
    ,.req_i(dma_req_i)
    ,.yumi_o(dma_req_yumi_o)
    ,.chan_req_o(chan_req)
    ,.chan_rsp_i(chan_rsp)
    ,.rsp_o(dma_rsp_o)
  );

  mc_test_dram #(
    .dram_latency_p(dram_latency_p)
  ) dram (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.chan_req_i(chan_req)
    ,.chan_rsp_o(chan_rsp)
  );

endmodule

// ==== logic/mc_test_dram.sv ====
module mc_test_dram #(
  parameter int dram_latency_p = 4
) (
  input  logic clk_i
  , input  logic arst_n_i

  , input  mc_dma_pkg::chan_req_s chan_req_i
  , output mc_dma_pkg::chan_rsp_s chan_rsp_o
);

  localparam int words_lp = 2 ** mc_dma_pkg::ADDR_W;

  mc_dma_pkg::dram_addr_s dram_addr;

  logic rd_en;
  logic wr_en;

  // storage, indexed by the remapped address
  logic [mc_dma_pkg::DATA_W-1:0] mem_r [words_lp];

  // read return pipeline
  logic [dram_latency_p-1:0]                         vld_r;
  logic [dram_latency_p-1:0][mc_dma_pkg::DATA_W-1:0] data_r;
  mc_dma_pkg::id_t [dram_latency_p-1:0]              id_r;

  ////////////////////
  // address remap
  ////////////////////

  // cache order ba bg ro co becomes ro bg ba co
  assign dram_addr = '{
    ro: chan_req_i.addr.ro,
    bg: chan_req_i.addr.bg,
    ba: chan_req_i.addr.ba,
    co: chan_req_i.addr.co
  };

  assign rd_en = chan_req_i.v && (chan_req_i.op == mc_dma_pkg::DMA_READ);
  assign wr_en = chan_req_i.v && (chan_req_i.op == mc_dma_pkg::DMA_WRITE);

  ////////////////////
  // storage and read data
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_r[dram_addr] <= chan_req_i.data;
    end
    // sampled at the acceptance edge
    if (rd_en) begin
      data_r[0] <= mem_r[dram_addr];
      id_r[0]   <= chan_req_i.id;
    end
    for (int s = 1; s < dram_latency_p; s++) begin
      data_r[s] <= data_r[s-1];
      id_r[s]   <= id_r[s-1];
    end
  end

  ////////////////////
  // valid pipeline
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_r <= '0;
    end else begin
      vld_r[0] <= rd_en;
      for (int s = 1; s < dram_latency_p; s++) begin
        vld_r[s] <= vld_r[s-1];
      end
    end
  end

  // last stage, dram_latency_p cycles after acceptance
  assign chan_rsp_o = '{
    v:    vld_r[dram_latency_p-1],
    data: data_r[dram_latency_p-1],
    id:   id_r[dram_latency_p-1]
  };

endmodule

// ==== verification/mc_mem_harness_chk.sv ====
module mc_mem_harness_chk #(
  parameter int num_vcaches_p = 4
) (
  input  logic clk_i
  , input  logic arst_n_i
  , input  logic tag_done_i
  , input  logic core_reset_i
  , input  mc_dma_pkg::dma_req_s [num_vcaches_p-1:0] dma_req_i
  , input  logic [num_vcaches_p-1:0]                 yumi_i
  , input  mc_dma_pkg::dma_rsp_s [num_vcaches_p-1:0] rsp_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  logic [num_vcaches_p-1:0] rsp_v;

  always_comb begin
    for (int i = 0; i < num_vcaches_p; i++) begin
      rsp_v[i] = rsp_i[i].v;
    end
  end

  ////////////////////
  // strobes and reset
  ////////////////////

  a_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(yumi_i))
    else begin
      $error("yumi vector has more than one bit set");
      fail_cnt++;
    end

  a_core_reset: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    core_reset_i |-> (yumi_i == '0))
    else begin
      $error("yumi raised while the cores are in reset");
      fail_cnt++;
    end

  a_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> (!tag_done_i && (yumi_i == '0) && (rsp_v == '0)))
    else begin
      $error("outputs not cleared during reset");
      fail_cnt++;
    end

  // per requester handshake
  for (genvar g = 0; g < num_vcaches_p; g++) begin : g_req
    a_yumi_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      yumi_i[g] |-> dma_req_i[g].v)
      else begin
        $error("yumi %0d raised without a valid request", g);
        fail_cnt++;
      end

    a_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (dma_req_i[g].v && !yumi_i[g]) |=> (dma_req_i[g].v && $stable(dma_req_i[g])))
      else begin
        $error("request %0d changed before acceptance", g);
        fail_cnt++;
      end

    a_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (dma_req_i[g].v && !yumi_i[g]) |-> ##[1:32] yumi_i[g])
      else begin
        $error("request %0d never accepted", g);
        fail_cnt++;
      end
  end

endmodule

bind mc_mem_harness mc_mem_harness_chk #(
  .num_vcaches_p(num_vcaches_p)
) chk (
  .clk_i(clk_i)
  ,.arst_n_i(arst_n_i)
  ,.tag_done_i(tag_done_o)
  ,.core_reset_i(core_reset)
  ,.dma_req_i(dma_req_i)
  ,.yumi_i(dma_req_yumi_o)
  ,.rsp_i(dma_rsp_o)
);

// ==== verification/tb_mc_mem_harness.sv ====
module tb_mc_mem_harness;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_vc_lp      = 4;
  localparam int depth_lp       = 3;
  localparam int lat_lp         = 4;
  localparam int boot_lp        = mc_machine_pkg::TAG_CYCLES + depth_lp;
  localparam int drain_limit_lp = 64;
  localparam int idle_limit_lp  = 32;

  // one outstanding read as the scoreboard expects it
  typedef struct packed {
    int unsigned     due;
    mc_dma_pkg::id_t id;
    logic [31:0]     data;
  } rd_exp_s;

  logic                                 clk = 1'b0;
  logic                                 arst_n;
  logic                                 tag_done;
  mc_dma_pkg::dma_req_s [num_vc_lp-1:0] req;
  logic [num_vc_lp-1:0]                 yumi;
  mc_dma_pkg::dma_rsp_s [num_vc_lp-1:0] rsp;

  logic [num_vc_lp-1:0] pending;
  int unsigned          edges;
  int                   last_win;
  int                   wait_cnt [num_vc_lp];
  int                   first_yumi_k;
  int                   reads_acc;
  int                   rsp_seen;
  int                   err_cnt;
  int                   chk_cnt;
  rd_exp_s              exp_q [$];
  logic [31:0]          sb [logic [9:0]];
  logic [9:0]           addr_list [$];

  mc_mem_harness uut (
    .clk_i(clk)
    ,.arst_n_i(arst_n)
    ,.tag_done_o(tag_done)
    ,.dma_req_i(req)
    ,.dma_req_yumi_o(yumi)
    ,.dma_rsp_o(rsp)
  );

  always #10 clk = ~clk;

  // rising edges since reset release
  always @(posedge clk) begin
    if (arst_n) begin
      edges++;
    end
  end

  ////////////////////
  // reporting
  ////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("check failed at %0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic abort_run(input string why);
    err_cnt++;
    $display("timeout: %s", why);
    $display("checks %0d, errors %0d, assertion failures %0d",
             chk_cnt, err_cnt, uut.chk.fail_cnt);
    $display("Verification failed");
    $finish;
  endtask

  ////////////////////
  // monitor
  ////////////////////

  task automatic score_responses();
    logic [num_vc_lp-1:0] exp_v;
    rd_exp_s              head;
    exp_v = '0;
    head  = '0;
    if (exp_q.size() != 0 && exp_q[0].due == edges) begin
      head = exp_q.pop_front();
      exp_v[head.id] = 1'b1;
    end
    for (int i = 0; i < num_vc_lp; i++) begin
      compare_value($sformatf("dma_rsp_o[%0d].v", i), 32'(rsp[i].v), 32'(exp_v[i]));
      if (rsp[i].v) begin
        rsp_seen++;
      end
      if (rsp[i].v && exp_v[i]) begin
        compare_value($sformatf("dma_rsp_o[%0d].data", i), rsp[i].data, head.data);
      end
    end
  endtask

  task automatic watch_boot();
    compare_value("tag_done_o", 32'(tag_done),
                  32'(edges >= mc_machine_pkg::TAG_CYCLES));
    if (edges < boot_lp) begin
      compare_value("dma_req_yumi_o", 32'(yumi), 32'h0);
    end
  endtask

  task automatic model_arbiter();
    logic [num_vc_lp-1:0] vld;
    int                   exp_win;
    int                   win;
    int                   idx;
    logic [9:0]           a;
    rd_exp_s              e;
    vld     = '0;
    exp_win = -1;
    win     = -1;
    for (int i = 0; i < num_vc_lp; i++) begin
      vld[i] = req[i].v;
      if (yumi[i] && win < 0) begin
        win = i;
      end
    end
    // search starts one past the previous winner
    for (int k = 1; k <= num_vc_lp; k++) begin
      idx = (last_win + k) % num_vc_lp;
      if (exp_win < 0 && vld[idx]) begin
        exp_win = idx;
      end
    end
    if (edges >= boot_lp && exp_win >= 0) begin
      compare_value("dma_req_yumi_o", 32'(yumi), 32'(1) << exp_win);
    end
    for (int i = 0; i < num_vc_lp; i++) begin
      if (!vld[i] || i == win) begin
        wait_cnt[i] = 0;
      end else if (win >= 0) begin
        wait_cnt[i]++;
        assert (wait_cnt[i] <= num_vc_lp - 1) else note_failure("requester starved");
      end
    end
    if (win >= 0) begin
      if (first_yumi_k < 0) begin
        first_yumi_k = int'(edges);
      end
      assert (vld[win]) else note_failure("yumi raised with no valid request");
      last_win = win;
      a = req[win].addr;
      if (req[win].op == mc_dma_pkg::DMA_WRITE) begin
        sb[a] = req[win].data;
      end else begin
        e.data = 32'hx;
        if (sb.exists(a)) begin
          e.data = sb[a];
        end else begin
          note_failure("read of an address never written");
        end
        e.due = edges + lat_lp;
        e.id  = mc_dma_pkg::id_t'(win);
        exp_q.push_back(e);
        reads_acc++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      score_responses();
      watch_boot();
      model_arbiter();
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic post_request(input int idx, input mc_dma_pkg::dma_op_e op,
                              input logic [9:0] addr, input logic [31:0] data);
    req[idx].v    = 1'b1;
    req[idx].op   = op;
    req[idx].addr = mc_dma_pkg::cache_addr_s'(addr);
    req[idx].data = data;
    pending[idx]  = 1'b1;
  endtask

  // drop each request on the edge after its yumi,
  // or post a fresh write in its place while refills remain
  task automatic await_acceptance(input int refills);
    logic [num_vc_lp-1:0] taken;
    logic [9:0]           a;
    int                   guard;
    guard = 0;
    while (pending != '0 && guard <= drain_limit_lp) begin
      @(negedge clk);
      taken = pending & yumi;
      @(posedge clk);
      #2;
      for (int i = 0; i < num_vc_lp; i++) begin
        if (taken[i] && refills > 0) begin
          a = 10'($urandom());
          addr_list.push_back(a);
          post_request(i, mc_dma_pkg::DMA_WRITE, a, $urandom());
          refills--;
        end else if (taken[i]) begin
          req[i].v   = 1'b0;
          pending[i] = 1'b0;
        end
      end
      guard++;
    end
    if (pending != '0) begin
      abort_run("requests were not accepted in time");
    end
  endtask

  task automatic await_idle();
    int guard;
    guard = 0;
    while (exp_q.size() != 0 && guard < idle_limit_lp) begin
      @(posedge clk);
      guard++;
    end
    if (exp_q.size() != 0) begin
      abort_run("read responses still outstanding");
    end
  endtask

  function automatic logic [9:0] written_addr();
    return addr_list[$urandom_range(addr_list.size() - 1)];
  endfunction

  initial begin
    logic [9:0]           a;
    logic [num_vc_lp-1:0] mask;
    arst_n       = 1'b1;
    req          = '0;
    pending      = '0;
    edges        = 0;
    last_win     = num_vc_lp - 1;
    first_yumi_k = -1;
    reads_acc    = 0;
    rsp_seen     = 0;
    err_cnt      = 0;
    chk_cnt      = 0;
    for (int i = 0; i < num_vc_lp; i++) begin
      wait_cnt[i] = 0;
    end
    void'($urandom(32'h6b60_9671));
    #5 arst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2 arst_n = 1'b1;

    // held through boot, granted once core reset drops
    a = 10'($urandom());
    addr_list.push_back(a);
    post_request(2, mc_dma_pkg::DMA_WRITE, a, $urandom());
    await_acceptance(0);
    compare_value("first grant edge", first_yumi_k, boot_lp);

    // writes, one in three overwriting an earlier address
    repeat (16) begin
      if ($urandom_range(2) == 0) begin
        a = written_addr();
      end else begin
        a = 10'($urandom());
        addr_list.push_back(a);
      end
      post_request($urandom_range(num_vc_lp - 1), mc_dma_pkg::DMA_WRITE, a, $urandom());
      await_acceptance(0);
    end
    repeat (20) begin
      post_request($urandom_range(num_vc_lp - 1), mc_dma_pkg::DMA_READ, written_addr(), '0);
      await_acceptance(0);
    end

    // round robin with every requester, then random subsets
    repeat (6) begin
      for (int i = 0; i < num_vc_lp; i++) begin
        a = 10'($urandom());
        addr_list.push_back(a);
        post_request(i, mc_dma_pkg::DMA_WRITE, a, $urandom());
      end
      await_acceptance(0);
    end

    // continuous demand, each winner posts again at once
    for (int i = 0; i < num_vc_lp; i++) begin
      a = 10'($urandom());
      addr_list.push_back(a);
      post_request(i, mc_dma_pkg::DMA_WRITE, a, $urandom());
    end
    await_acceptance(6 * num_vc_lp);

    repeat (8) begin
      mask = num_vc_lp'($urandom_range(1, (1 << num_vc_lp) - 1));
      for (int i = 0; i < num_vc_lp; i++) begin
        if (mask[i]) begin
          post_request(i, mc_dma_pkg::DMA_READ, written_addr(), '0);
        end
      end
      await_acceptance(0);
    end

    // back to back reads keep the pipeline full
    repeat (3) begin
      for (int i = 0; i < num_vc_lp; i++) begin
        post_request(i, mc_dma_pkg::DMA_READ, written_addr(), '0);
      end
      await_acceptance(0);
    end

    await_idle();
    repeat (lat_lp) @(posedge clk);
    compare_value("response count", rsp_seen, reads_acc);

    $display("checks %0d, errors %0d, assertion failures %0d",
             chk_cnt, err_cnt, uut.chk.fail_cnt);
    if (err_cnt == 0 && uut.chk.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
